// File: verilog/rv_fetch_pkg.sv
package rv_fetch_pkg;

  localparam int XLEN = 32;

  typedef logic [XLEN-1:0] xlen_t;

  // Major opcodes that matter to the front end
  typedef enum logic [6:0] {
    OPCODE_JAL    = 7'b1101111,
    OPCODE_JALR   = 7'b1100111,
    OPCODE_BRANCH = 7'b1100011
  } opcode_e;

  // Instruction class handed to decode
  typedef enum logic [2:0] {
    OPC_OTHER  = 3'd0,
    OPC_JAL    = 3'd1,
    OPC_JALR   = 3'd2,
    OPC_BRANCH = 3'd3
  } opclass_e;

  // BTB training strobe from a later stage
  typedef struct packed {
    logic  valid;
    xlen_t pc;
    xlen_t target;
  } btb_upd_t;

  // Redirect strobe, also flushes everything in flight
  typedef struct packed {
    logic  valid;
    xlen_t pc;
  } redirect_t;

  // IF/ID register contents
  typedef struct packed {
    logic  valid;
    xlen_t instr;
    xlen_t pc;
    logic  pred_taken;
    xlen_t pred_tgt;
  } if_id_t;

  // Registered packet toward decode
  typedef struct packed {
    logic     valid;
    opclass_e opclass;
    xlen_t    instr;
    xlen_t    pc;
    xlen_t    pc_plus4;
    logic     pred_taken;
    xlen_t    pred_tgt;
    xlen_t    imm_tgt;
  } id_pkt_t;

endpackage

// File: verilog/rv_btb.sv
`timescale 1ns/1ps

module rv_btb #(
  parameter int BTB_ENTRIES = 16
) (
  input  logic                  clk,
  input  logic                  reset_i,
  input  rv_fetch_pkg::xlen_t   lookup_pc_i,
  output logic                  hit_o,
  output rv_fetch_pkg::xlen_t   target_o,
  input  rv_fetch_pkg::btb_upd_t upd_i
);

  import rv_fetch_pkg::*;

  localparam int IDX_W = $clog2(BTB_ENTRIES);
  // Bits [1:0] are always zero for 32-bit instructions
  localparam int TAG_W = XLEN - 2 - IDX_W;

  logic [BTB_ENTRIES-1:0] valid_q;
  logic [TAG_W-1:0]       tag_q [BTB_ENTRIES];
  xlen_t                  tgt_q [BTB_ENTRIES];

  logic [IDX_W-1:0] lookup_idx;
  logic [TAG_W-1:0] lookup_tag;
  logic [IDX_W-1:0] upd_idx;
  logic [TAG_W-1:0] upd_tag;

  assign lookup_idx = lookup_pc_i[IDX_W+1:2];
  assign lookup_tag = lookup_pc_i[XLEN-1:IDX_W+2];
  assign upd_idx    = upd_i.pc[IDX_W+1:2];
  assign upd_tag    = upd_i.pc[XLEN-1:IDX_W+2];

  // Combinational lookup on the current fetch PC
  assign hit_o    = valid_q[lookup_idx] && (tag_q[lookup_idx] == lookup_tag);
  assign target_o = tgt_q[lookup_idx];

  always_ff @(posedge clk) begin
    if (reset_i) begin
      valid_q <= '0;
    end else if (upd_i.valid) begin
      valid_q[upd_idx] <= 1'b1;
    end
  end

  // Tag and target storage, overwritten by each update
  always_ff @(posedge clk) begin
    if (upd_i.valid) begin
      tag_q[upd_idx] <= upd_tag;
      tgt_q[upd_idx] <= upd_i.target;
    end
  end

endmodule

// File: verilog/rv_pc_gen.sv
`timescale 1ns/1ps

module rv_pc_gen #(
  parameter rv_fetch_pkg::xlen_t RESET_PC = 32'h0000_1000
) (
  input  logic                   clk,
  input  logic                   reset_i,
  input  logic                   stall_i,
  input  rv_fetch_pkg::redirect_t redirect_i,
  input  logic                   btb_hit_i,
  input  rv_fetch_pkg::xlen_t    btb_target_i,
  output rv_fetch_pkg::xlen_t    pc_o,
  output logic                   pred_taken_o,
  output rv_fetch_pkg::xlen_t    pred_tgt_o,
  output logic                   imem_arvalid_o,
  output rv_fetch_pkg::xlen_t    imem_araddr_o
);

  import rv_fetch_pkg::*;

  xlen_t pc_q;
  logic  run_q;
  xlen_t pc_seq;
  xlen_t pc_pred;
  logic  issue;

  // Fetching starts one cycle after reset is released
  always_ff @(posedge clk) begin
    if (reset_i) begin
      run_q <= 1'b0;
    end else begin
      run_q <= 1'b1;
    end
  end

  assign issue  = run_q && !stall_i;
  assign pc_seq = pc_q + 32'd4;

  // Predicted next PC for the address being issued now
  assign pc_pred = btb_hit_i ? btb_target_i : pc_seq;

  // Redirect wins over stall and over the prediction
  always_ff @(posedge clk) begin
    if (reset_i) begin
      pc_q <= RESET_PC;
    end else if (redirect_i.valid) begin
      pc_q <= redirect_i.pc;
    end else if (issue) begin
      pc_q <= pc_pred;
    end
  end

  assign imem_arvalid_o = issue;
  assign imem_araddr_o  = pc_q;

  // Request side-band, registered by the IF stage
  assign pc_o         = pc_q;
  assign pred_taken_o = btb_hit_i;
  assign pred_tgt_o   = pc_pred;

endmodule

// File: verilog/rv_stage_if.sv
`timescale 1ns/1ps

module rv_stage_if (
  input  logic                 clk,
  input  logic                 reset_i,
  input  logic                 stall_i,
  input  logic                 flush_i,
  input  logic                 fetch_valid_i,
  input  rv_fetch_pkg::xlen_t  pc_i,
  input  logic                 pred_taken_i,
  input  rv_fetch_pkg::xlen_t  pred_tgt_i,
  input  rv_fetch_pkg::xlen_t  imem_rdata_i,
  output rv_fetch_pkg::if_id_t if_id_o
);

  import rv_fetch_pkg::*;

  logic  valid_q;
  xlen_t pc_q;
  logic  pred_taken_q;
  xlen_t pred_tgt_q;

  // Capture the side-band of each accepted request
  //
  // The memory returns the matching word in the following cycle and
  // keeps it while no new request is accepted, so under stall the
  // registered fields and the read data stay paired
  always_ff @(posedge clk) begin
    if (reset_i || flush_i) begin
      valid_q <= 1'b0;
    end else if (!stall_i) begin
      valid_q      <= fetch_valid_i;
      pc_q         <= pc_i;
      pred_taken_q <= pred_taken_i;
      pred_tgt_q   <= pred_tgt_i;
    end
  end

  always_comb begin
    if_id_o.valid      = valid_q;
    if_id_o.instr      = imem_rdata_i;
    if_id_o.pc         = pc_q;
    if_id_o.pred_taken = pred_taken_q;
    if_id_o.pred_tgt   = pred_tgt_q;
  end

endmodule

// File: verilog/rv_predecode.sv
`timescale 1ns/1ps

module rv_predecode (
  input  logic                  clk,
  input  logic                  reset_i,
  input  logic                  stall_i,
  input  logic                  flush_i,
  input  rv_fetch_pkg::if_id_t  if_id_i,
  output rv_fetch_pkg::id_pkt_t id_o
);

  import rv_fetch_pkg::*;

  xlen_t    instr;
  xlen_t    imm_j;
  xlen_t    imm_b;
  opclass_e opclass;
  xlen_t    imm_tgt;
  id_pkt_t  pkt_d;
  id_pkt_t  pkt_q;

  assign instr = if_id_i.instr;

  // Sign-extended control-flow immediates
  assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
  assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};

  always_comb begin
    case (instr[6:0])
      OPCODE_JAL: begin
        opclass = OPC_JAL;
        imm_tgt = if_id_i.pc + imm_j;
      end
      OPCODE_JALR: begin
        // Target depends on a register, not known here
        opclass = OPC_JALR;
        imm_tgt = '0;
      end
      OPCODE_BRANCH: begin
        opclass = OPC_BRANCH;
        imm_tgt = if_id_i.pc + imm_b;
      end
      default: begin
        opclass = OPC_OTHER;
        imm_tgt = '0;
      end
    endcase
  end

  always_comb begin
    pkt_d.valid      = if_id_i.valid;
    pkt_d.opclass    = opclass;
    pkt_d.instr      = instr;
    pkt_d.pc         = if_id_i.pc;
    pkt_d.pc_plus4   = if_id_i.pc + 32'd4;
    pkt_d.pred_taken = if_id_i.pred_taken;
    pkt_d.pred_tgt   = if_id_i.pred_tgt;
    pkt_d.imm_tgt    = imm_tgt;
  end

  // Flush drops the packet even while stalled
  always_ff @(posedge clk) begin
    if (reset_i || flush_i) begin
      pkt_q.valid <= 1'b0;
    end else if (!stall_i) begin
      pkt_q <= pkt_d;
    end
  end

  assign id_o = pkt_q;

endmodule

// File: verilog/rv_fetch_top.sv
`timescale 1ns/1ps

module rv_fetch_top #(
  parameter rv_fetch_pkg::xlen_t RESET_PC    = 32'h0000_1000,
  parameter int                  BTB_ENTRIES = 16
) (
  input  logic                    clk,
  input  logic                    reset_i,
  input  logic                    stall_i,
  input  rv_fetch_pkg::redirect_t redirect_i,
  input  rv_fetch_pkg::btb_upd_t  btb_upd_i,
  output logic                    imem_arvalid_o,
  output rv_fetch_pkg::xlen_t     imem_araddr_o,
  input  rv_fetch_pkg::xlen_t     imem_rdata_i,
  output rv_fetch_pkg::id_pkt_t   id_o
);

  import rv_fetch_pkg::*;

  logic   btb_hit;
  xlen_t  btb_target;
  xlen_t  fetch_pc;
  logic   pred_taken;
  xlen_t  pred_tgt;
  if_id_t if_id;
  logic   flush;

  // A redirect kills both pipeline stages
  assign flush = redirect_i.valid;

  rv_btb #(
    .BTB_ENTRIES(BTB_ENTRIES)
  ) rv_btb_inst (
    .clk        (clk),
    .reset_i    (reset_i),
    .lookup_pc_i(fetch_pc),
    .hit_o      (btb_hit),
    .target_o   (btb_target),
    .upd_i      (btb_upd_i)
  );

  rv_pc_gen #(
    .RESET_PC(RESET_PC)
  ) rv_pc_gen_inst (
    .clk           (clk),
    .reset_i       (reset_i),
    .stall_i       (stall_i),
    .redirect_i    (redirect_i),
    .btb_hit_i     (btb_hit),
    .btb_target_i  (btb_target),
    .pc_o          (fetch_pc),
    .pred_taken_o  (pred_taken),
    .pred_tgt_o    (pred_tgt),
    .imem_arvalid_o(imem_arvalid_o),
    .imem_araddr_o (imem_araddr_o)
  );

  rv_stage_if rv_stage_if_inst (
    .clk          (clk),
    .reset_i      (reset_i),
    .stall_i      (stall_i),
    .flush_i      (flush),
    .fetch_valid_i(imem_arvalid_o),
    .pc_i         (fetch_pc),
    .pred_taken_i (pred_taken),
    .pred_tgt_i   (pred_tgt),
    .imem_rdata_i (imem_rdata_i),
    .if_id_o      (if_id)
  );

  rv_predecode rv_predecode_inst (
    .clk    (clk),
    .reset_i(reset_i),
    .stall_i(stall_i),
    .flush_i(flush),
    .if_id_i(if_id),
    .id_o   (id_o)
  );

endmodule

// File: verification/rv_fetch_asserts.sv
`timescale 1ns/1ps

module rv_fetch_asserts #(
  parameter int W = 1
) (
  input logic         clk,
  input logic         reset_i,
  input logic         stall_i,
  input logic         flush_i,
  input logic         valid_i,
  input logic [W-1:0] data_i
);

  // A valid entry must not move while stalled
  property p_stall_holds_data;
    @(posedge clk) (!reset_i && stall_i && !flush_i && valid_i) |=> $stable(data_i);
  endproperty

  property p_stall_holds_valid;
    @(posedge clk) (!reset_i && stall_i && !flush_i) |=> (valid_i == $past(valid_i));
  endproperty

  // Redirect wins over stall
  property p_flush_clears;
    @(posedge clk) (reset_i || flush_i) |=> !valid_i;
  endproperty

  a_stall_holds_data: assert property (p_stall_holds_data)
    else $error("stalled entry changed its contents");

  a_stall_holds_valid: assert property (p_stall_holds_valid)
    else $error("stalled entry changed its valid bit");

  a_flush_clears: assert property (p_flush_clears)
    else $error("entry still valid after flush or reset");

endmodule

bind rv_stage_if rv_fetch_asserts #(
  .W($bits(rv_fetch_pkg::if_id_t))
) if_asserts_inst (
  .clk    (clk),
  .reset_i(reset_i),
  .stall_i(stall_i),
  .flush_i(flush_i),
  .valid_i(if_id_o.valid),
  .data_i (if_id_o)
);

bind rv_predecode rv_fetch_asserts #(
  .W($bits(rv_fetch_pkg::id_pkt_t))
) id_asserts_inst (
  .clk    (clk),
  .reset_i(reset_i),
  .stall_i(stall_i),
  .flush_i(flush_i),
  .valid_i(id_o.valid),
  .data_i (id_o)
);

// File: verification/rv_fetch_tb.sv
`timescale 1ns/1ps

module rv_fetch_tb;

  import rv_fetch_pkg::*;

  localparam logic [31:0] SEED       = 32'h7091_4d98;
  localparam int          NUM_CYCLES = 2000;
  localparam int          WARMUP     = 40;

  logic      clk;
  logic      reset_i;
  logic      stall_i;
  redirect_t redirect_i;
  btb_upd_t  btb_upd_i;
  logic      imem_arvalid_o;
  xlen_t     imem_araddr_o;
  xlen_t     imem_rdata_i;
  id_pkt_t   id_o;

  // Reference model state
  xlen_t     rng_state;
  xlen_t     reset_pc;
  int        btb_entries;
  xlen_t     exp_pc;
  id_pkt_t   exp_q[$];
  xlen_t     mem [xlen_t];
  xlen_t     mir_pc [int];
  xlen_t     mir_tgt [int];
  logic      req_v;
  xlen_t     req_a;
  logic      hold_id;
  id_pkt_t   prev_id;
  int        stall_left;
  int        taken_seen;
  int        redirects_seen;
  int        transfers;

  rv_fetch_top rv_fetch_top_inst (
    .clk           (clk),
    .reset_i       (reset_i),
    .stall_i       (stall_i),
    .redirect_i    (redirect_i),
    .btb_upd_i     (btb_upd_i),
    .imem_arvalid_o(imem_arvalid_o),
    .imem_araddr_o (imem_araddr_o),
    .imem_rdata_i  (imem_rdata_i),
    .id_o          (id_o)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  function automatic xlen_t xorshift32(xlen_t x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic xlen_t next_rand();
    rng_state = xorshift32(rng_state);
    return rng_state;
  endfunction

  // Sparse memory with each word hashed from its full address
  function automatic xlen_t mem_word(xlen_t addr);
    xlen_t w;
    xlen_t sel;
    if (!mem.exists(addr)) begin
      w   = xorshift32(xorshift32(addr ^ 32'h5bd1_e995));
      sel = xorshift32(w);
      // One word in eight becomes a JAL or a conditional branch
      if (sel[2:0] == 3'd0) begin
        w[6:0] = sel[3] ? 7'b1101111 : 7'b1100011;
      end
      mem[addr] = w;
    end
    return mem[addr];
  endfunction

  function automatic int btb_index(xlen_t pc);
    return int'((pc >> 2) & xlen_t'(btb_entries - 1));
  endfunction

  // Decode packet expected for one fetched PC
  function automatic id_pkt_t expected_packet(xlen_t pc, logic taken, xlen_t tgt);
    id_pkt_t     p;
    xlen_t       w;
    logic [20:0] j_imm;
    logic [12:0] b_imm;
    w            = mem_word(pc);
    j_imm        = {w[31], w[19:12], w[20], w[30:21], 1'b0};
    b_imm        = {w[31], w[7], w[30:25], w[11:8], 1'b0};
    p.valid      = 1'b1;
    p.instr      = w;
    p.pc         = pc;
    p.pc_plus4   = pc + 32'd4;
    p.pred_taken = taken;
    p.pred_tgt   = tgt;
    p.opclass    = OPC_OTHER;
    p.imm_tgt    = '0;
    case (w[6:0])
      7'b1101111: begin
        p.opclass = OPC_JAL;
        p.imm_tgt = pc + {{11{j_imm[20]}}, j_imm};
      end
      7'b1100111: begin
        p.opclass = OPC_JALR;
      end
      7'b1100011: begin
        p.opclass = OPC_BRANCH;
        p.imm_tgt = pc + {{19{b_imm[12]}}, b_imm};
      end
      default: begin
      end
    endcase
    return p;
  endfunction

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Verification failed");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic compare_id(input string name, input id_pkt_t got, input id_pkt_t exp);
    if (got !== exp) begin
      abort_run($sformatf("Mismatch at %0t ns: %s expected %h got %h", $time, name, exp, got));
    end
  endtask

  task automatic compare_req(input string name, input xlen_t got, input xlen_t exp);
    if (got !== exp) begin
      abort_run($sformatf("Mismatch at %0t ns: %s expected %h got %h", $time, name, exp, got));
    end
  endtask

  task automatic compare_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      abort_run($sformatf("Mismatch at %0t ns: %s expected %b got %b", $time, name, exp, got));
    end
  endtask

  // Runs at the falling edge where inputs and outputs are settled
  task automatic observe_cycle();
    logic    hit;
    logic    issue;
    xlen_t   tgt;
    id_pkt_t got;
    id_pkt_t want;
    int      idx;
    got   = id_o;
    issue = !stall_i;
    compare_bit("imem_arvalid_o", imem_arvalid_o, issue);
    if (hold_id) begin
      compare_id("id_o under stall", got, prev_id);
    end
    if (got.valid && !stall_i && !redirect_i.valid) begin
      if (exp_q.size() == 0) begin
        abort_run($sformatf("Transfer on id_o at %0t ns with no item in flight", $time));
      end else begin
        want = exp_q.pop_front();
        compare_id("id_o", got, want);
        if (want.pred_taken) begin
          taken_seen++;
        end
        transfers++;
      end
    end
    if (issue) begin
      compare_req("imem_araddr_o", imem_araddr_o, exp_pc);
      idx = btb_index(exp_pc);
      hit = mir_pc.exists(idx) && (mir_pc[idx] == exp_pc);
      tgt = hit ? mir_tgt[idx] : exp_pc + 32'd4;
      if (!redirect_i.valid) begin
        exp_q.push_back(expected_packet(exp_pc, hit, tgt));
      end
      exp_pc = tgt;
    end
    if (redirect_i.valid) begin
      exp_q.delete();
      exp_pc = redirect_i.pc;
      redirects_seen++;
    end
    // Training takes effect after the lookup of this cycle
    if (btb_upd_i.valid) begin
      mir_pc[btb_index(btb_upd_i.pc)]  = btb_upd_i.pc;
      mir_tgt[btb_index(btb_upd_i.pc)] = btb_upd_i.target;
    end
    if (exp_q.size() > 2) begin
      abort_run($sformatf("Item missing from id_o at %0t ns, too many in flight", $time));
    end
    req_v   = issue;
    req_a   = imem_araddr_o;
    hold_id = stall_i && !redirect_i.valid;
    prev_id = got;
  endtask

  task automatic drive_stimulus(input int cyc);
    xlen_t r;
    stall_i    = 1'b0;
    redirect_i = '0;
    btb_upd_i  = '0;
    // Plain sequential fetch during warmup
    if (cyc >= WARMUP) begin
      r = next_rand();
      if (stall_left > 0) begin
        stall_i = 1'b1;
        stall_left--;
      end else if (r[2:0] == 3'd0) begin
        stall_i    = 1'b1;
        stall_left = int'(r[5:3]) % 5;
      end
      r = next_rand();
      if (r[4:0] == 5'd0) begin
        redirect_i.valid = 1'b1;
        redirect_i.pc    = reset_pc + {22'd0, r[15:8], 2'b00};
      end
      r = next_rand();
      if (r[3:0] == 4'd0) begin
        btb_upd_i.valid  = 1'b1;
        // Train a PC just ahead of the fetch point so the prediction shows up soon
        btb_upd_i.pc     = exp_pc + {28'd0, r[6:5], 2'b00};
        btb_upd_i.target = reset_pc + {22'd0, r[15:8], 2'b00};
      end
    end
  endtask

  task automatic wait_first_request();
    int n;
    n = 0;
    while (!imem_arvalid_o && n < 10) begin
      @(negedge clk);
      n++;
    end
    if (!imem_arvalid_o) begin
      abort_run("Timeout while waiting for the first fetch request");
    end else begin
      compare_req("imem_araddr_o", imem_araddr_o, reset_pc);
    end
  endtask

  initial begin
    reset_i        = 1'b1;
    stall_i        = 1'b0;
    redirect_i     = '0;
    btb_upd_i      = '0;
    imem_rdata_i   = '0;
    rng_state      = SEED;
    reset_pc       = rv_fetch_top_inst.RESET_PC;
    btb_entries    = rv_fetch_top_inst.BTB_ENTRIES;
    exp_pc         = reset_pc;
    req_v          = 1'b0;
    req_a          = '0;
    hold_id        = 1'b0;
    prev_id        = '0;
    stall_left     = 0;
    taken_seen     = 0;
    redirects_seen = 0;
    transfers      = 0;
    repeat (3) @(posedge clk);
    #1;
    reset_i = 1'b0;
    @(negedge clk);
    compare_bit("id_o.valid", id_o.valid, 1'b0);
    compare_bit("imem_arvalid_o", imem_arvalid_o, 1'b0);
    wait_first_request();
    for (int cyc = 0; cyc < NUM_CYCLES; cyc++) begin
      observe_cycle();
      @(posedge clk);
      #1;
      // Read data for the request accepted at this edge
      if (req_v) begin
        imem_rdata_i = mem_word(req_a);
      end
      drive_stimulus(cyc);
      @(negedge clk);
    end
    if (taken_seen == 0 || redirects_seen == 0 || transfers < 500) begin
      abort_run($sformatf("Too little activity, %0d transfers, %0d taken, %0d redirects",
                          transfers, taken_seen, redirects_seen));
    end else begin
      $display("Verification passed");
      $finish;
    end
  end

endmodule

// File: vlog.f
verilog/rv_fetch_pkg.sv
verilog/rv_btb.sv
verilog/rv_pc_gen.sv
verilog/rv_stage_if.sv
verilog/rv_predecode.sv
verilog/rv_fetch_top.sv
verification/rv_fetch_asserts.sv
verification/rv_fetch_tb.sv
